//--- hdl/l1d_pkg.sv
`default_nettype none

package l1d_pkg;

    // address layout, tag width follows from the index width
    parameter int ADDR_W = 32;
    parameter int OFFSET_W = 6;

    // one cpu data word
    typedef logic [31:0] word_t;

    // controller miss handling states
    typedef enum logic [1:0]
    {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/l1d_controller.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_controller #(
    parameter int INDEX_W = 6,
    localparam int TAG_W = l1d_pkg::ADDR_W - INDEX_W - l1d_pkg::OFFSET_W
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               cpu_req,
    input  logic               cpu_we,
    input  logic               flush,
    input  logic               l2_ready,
    input  logic [TAG_W-1:0]   tag,
    input  logic [INDEX_W-1:0] index,
    output logic               cpu_ack,
    output logic               refill,
    output logic               update,
    output logic               read_l2,
    output logic               write_l2,
    output logic [TAG_W-1:0]   victim_tag
);
    import l1d_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_arr [SETS];
    logic [SETS-1:0]  valid;
    logic [SETS-1:0]  dirty;

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic hit;
    logic miss;
    logic lookup_hit;
    logic fill_done;
    logic write_hit;
    logic flush_ok;

    assign lookup_hit = valid[index] && (tag_arr[index] == tag);
    assign fill_done  = (state == s_allocate) && l2_ready;
    assign write_hit  = (state == s_compare) && hit && cpu_we;
    // flush only between accesses
    assign flush_ok   = (state == s_idle) && flush && !cpu_req && !cpu_ack;
    assign victim_tag = tag_arr[index];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            s_idle:
                // ack still high means the last access has not closed yet
                if (cpu_req && !cpu_ack)
                    next_state = s_compare;
            s_compare:
                if (hit)
                    next_state = s_idle;
                else if (miss)
                    next_state = dirty[index] ? s_write_back : s_allocate;
            s_write_back:
                if (l2_ready)
                    next_state = s_allocate;
            s_allocate:
                if (l2_ready)
                    next_state = s_compare;
            default:
                next_state = s_idle;
        endcase
    end

    // lookup result, registered one cycle into compare
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
        else if (state == s_compare)
        begin
            hit  <= lookup_hit;
            miss <= !lookup_hit;
        end
        else
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
    end

    // ack held until the cpu drops its request
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            cpu_ack <= 1'b0;
        else if ((state == s_compare) && hit)
            cpu_ack <= 1'b1;
        else if ((state == s_idle) && !cpu_req)
            cpu_ack <= 1'b0;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (flush_ok)
        begin
            // dirty lines are dropped, not written back
            valid <= '0;
            dirty <= '0;
        end
        else if (fill_done)
        begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end
        else if (write_hit)
            dirty[index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_done)
            tag_arr[index] <= tag;
    end

    // strobes to the data array and the l2 side
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            refill   <= 1'b0;
            update   <= 1'b0;
            read_l2  <= 1'b0;
            write_l2 <= 1'b0;
        end
        else
        begin
            refill   <= fill_done;
            // write miss merges the word over the refill line
            update   <= (fill_done && cpu_we) || write_hit;
            read_l2  <= (state == s_allocate);
            write_l2 <= (state == s_write_back);
        end
    end

endmodule

`default_nettype wire

//--- hdl/l1d_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_data_array #(
    parameter int INDEX_W = 6,
    parameter int WORDS_PER_LINE = 16,
    localparam int SEL_W = $clog2(WORDS_PER_LINE),
    localparam int LINE_W = WORDS_PER_LINE * $bits(l1d_pkg::word_t)
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic [INDEX_W-1:0] index,
    input  logic [SEL_W-1:0]   word_sel,
    input  logic               refill,
    input  logic               update,
    input  l1d_pkg::word_t     wdata,
    input  logic [LINE_W-1:0]  fill_line,
    output l1d_pkg::word_t     rdata,
    output logic [LINE_W-1:0]  line_out
);
    import l1d_pkg::*;

    localparam int SETS = 1 << INDEX_W;
    localparam int WORD_W = $bits(word_t);

    logic [LINE_W-1:0] lines [SETS];
    logic [LINE_W-1:0] next_line;
    logic              wr_en;

    // addressed line and word, read without a clock
    assign line_out = lines[index];
    assign rdata    = line_out[word_sel*WORD_W +: WORD_W];

    // no writes while reset is held
    assign wr_en = nrst && (refill || update);

    always_comb
    begin
        next_line = refill ? fill_line : line_out;
        if (update)
            next_line[word_sel*WORD_W +: WORD_W] = wdata;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            lines[index] <= next_line;
    end

endmodule

`default_nettype wire

//--- hdl/l2_handshake.sv
`timescale 1ns/1ps
`default_nettype none

module l2_handshake #(
    parameter int WORDS_PER_LINE = 16,
    localparam int LINE_W = WORDS_PER_LINE * $bits(l1d_pkg::word_t)
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       read_l2,
    input  logic                       write_l2,
    input  logic [l1d_pkg::ADDR_W-1:0] line_addr,
    input  logic [LINE_W-1:0]          wline,
    input  logic                       l2_ack,
    input  logic [LINE_W-1:0]          l2_rline,
    output logic                       l2_req,
    output logic                       l2_we,
    output logic [l1d_pkg::ADDR_W-1:0] l2_addr,
    output logic [LINE_W-1:0]          l2_wline,
    output logic [LINE_W-1:0]          fill_line,
    output logic                       l2_ready
);
    typedef enum logic [1:0]
    {
        hs_idle,
        hs_wait_ack,
        hs_wait_release
    } hs_state_t;

    hs_state_t state;

    logic read_q;
    logic write_q;
    logic start;

    // one exchange per rising strobe edge
    assign start = (state == hs_idle) && ((read_l2 && !read_q) || (write_l2 && !write_q));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state    <= hs_idle;
            l2_req   <= 1'b0;
            l2_ready <= 1'b0;
            read_q   <= 1'b0;
            write_q  <= 1'b0;
        end
        else
        begin
            read_q   <= read_l2;
            write_q  <= write_l2;
            l2_ready <= 1'b0;
            case (state)
                hs_idle:
                    if (start)
                    begin
                        l2_req <= 1'b1;
                        state  <= hs_wait_ack;
                    end
                hs_wait_ack:
                    if (l2_ack)
                    begin
                        l2_req <= 1'b0;
                        state  <= hs_wait_release;
                    end
                hs_wait_release:
                    // done once the memory lets go of ack
                    if (!l2_ack)
                    begin
                        l2_ready <= 1'b1;
                        state    <= hs_idle;
                    end
                default:
                    state <= hs_idle;
            endcase
        end
    end

    // request payload and returned line
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            l2_we    <= write_l2;
            l2_addr  <= line_addr;
            l2_wline <= wline;
        end
        if ((state == hs_wait_ack) && l2_ack && !l2_we)
            fill_line <= l2_rline;
    end

endmodule

`default_nettype wire

//--- hdl/l1d_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_top #(
    parameter int INDEX_W = 6,
    parameter int WORDS_PER_LINE = 16,
    localparam int LINE_W = WORDS_PER_LINE * $bits(l1d_pkg::word_t)
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       cpu_req,
    input  logic                       cpu_we,
    input  logic [l1d_pkg::ADDR_W-1:0] cpu_addr,
    input  l1d_pkg::word_t             cpu_wdata,
    input  logic                       flush,
    output logic                       cpu_ack,
    output l1d_pkg::word_t             cpu_rdata,
    output logic                       l2_req,
    output logic                       l2_we,
    output logic [l1d_pkg::ADDR_W-1:0] l2_addr,
    output logic [LINE_W-1:0]          l2_wline,
    input  logic                       l2_ack,
    input  logic [LINE_W-1:0]          l2_rline
);
    import l1d_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SEL_W = $clog2(WORDS_PER_LINE);
    localparam int BYTE_W = $clog2($bits(word_t) / 8);

    logic [TAG_W-1:0]   tag;
    logic [TAG_W-1:0]   victim_tag;
    logic [INDEX_W-1:0] index;
    logic [SEL_W-1:0]   word_sel;
    logic [ADDR_W-1:0]  line_addr;
    logic [LINE_W-1:0]  line_out;
    logic [LINE_W-1:0]  fill_line;
    logic               refill;
    logic               update;
    logic               read_l2;
    logic               write_l2;
    logic               l2_ready;

    // byte bits below the word are ignored
    assign tag      = cpu_addr[ADDR_W-1 -: TAG_W];
    assign index    = cpu_addr[OFFSET_W +: INDEX_W];
    assign word_sel = cpu_addr[BYTE_W +: SEL_W];

    // write-back goes to the victim line, refill to the requested one
    assign line_addr = write_l2 ? {victim_tag, index, {OFFSET_W{1'b0}}}
                                : {tag, index, {OFFSET_W{1'b0}}};

    l1d_controller #(
        .INDEX_W    (INDEX_W)
    ) ctrl_i (
        .clk        (clk),
        .nrst       (nrst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .flush      (flush),
        .l2_ready   (l2_ready),
        .tag        (tag),
        .index      (index),
        .cpu_ack    (cpu_ack),
        .refill     (refill),
        .update     (update),
        .read_l2    (read_l2),
        .write_l2   (write_l2),
        .victim_tag (victim_tag)
    );

    l1d_data_array #(
        .INDEX_W        (INDEX_W),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) data_i (
        .clk       (clk),
        .nrst      (nrst),
        .index     (index),
        .word_sel  (word_sel),
        .refill    (refill),
        .update    (update),
        .wdata     (cpu_wdata),
        .fill_line (fill_line),
        .rdata     (cpu_rdata),
        .line_out  (line_out)
    );

    l2_handshake #(
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) hs_i (
        .clk       (clk),
        .nrst      (nrst),
        .read_l2   (read_l2),
        .write_l2  (write_l2),
        .line_addr (line_addr),
        .wline     (line_out),
        .l2_ack    (l2_ack),
        .l2_rline  (l2_rline),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wline  (l2_wline),
        .fill_line (fill_line),
        .l2_ready  (l2_ready)
    );

endmodule

`default_nettype wire

//--- sim/l2_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model #(
    parameter int          WORDS_PER_LINE = 16,
    parameter int          MEM_WORDS = 4096,
    parameter logic [31:0] FILL_KEY = 32'h5a3c9e71,
    parameter logic [31:0] SEED = 32'h1c2a0f63,
    localparam int         LINE_W = WORDS_PER_LINE * 32
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              l2_req,
    input  logic              l2_we,
    input  logic [31:0]       l2_addr,
    input  logic [LINE_W-1:0] l2_wline,
    output logic              l2_ack,
    output logic [LINE_W-1:0] l2_rline
);
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lfsr;
    int          delay;
    int          base;

    // fibonacci lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    initial
    begin
        lfsr     = SEED;
        l2_ack   = 1'b0;
        l2_rline = '0;
        // backing store pattern depends on the full word address
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = i ^ FILL_KEY;
        forever
        begin
            @(posedge clk);
            if (nrst && l2_req && !l2_ack)
            begin
                delay = take_bits(3);
                repeat (delay)
                    @(posedge clk);
                base = (l2_addr >> 2) % MEM_WORDS;
                for (int w = 0; w < WORDS_PER_LINE; w++)
                begin
                    if (l2_we)
                        mem[base + w] = l2_wline[w*32 +: 32];
                    else
                        l2_rline[w*32 +: 32] <= mem[base + w];
                end
                l2_ack <= 1'b1;
                // hold ack until the request goes away
                do
                begin
                    @(posedge clk);
                end
                while (l2_req);
                l2_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/l1d_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_tb;
    import l1d_pkg::*;

    localparam int          INDEX_W = 6;
    localparam int          WORDS_PER_LINE = 16;
    localparam int          LINE_W = WORDS_PER_LINE * 32;
    localparam int          SETS = 1 << INDEX_W;
    localparam int          SEL_W = $clog2(WORDS_PER_LINE);
    localparam int          TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int          MEM_WORDS = 4096;
    localparam logic [31:0] SEED = 32'h1c2a0f63;
    localparam logic [31:0] FILL_KEY = 32'h5a3c9e71;
    localparam int          RAND_ACCESSES = 200;
    localparam int          DELAY_ACCESSES = 150;
    localparam int          DIRECTED_ACCESSES = 23;
    localparam int          CYCLE_LIMIT =
        (RAND_ACCESSES + DELAY_ACCESSES + DIRECTED_ACCESSES) * 200;

    logic              clk;
    logic              nrst;
    logic              cpu_req;
    logic              cpu_we;
    logic [ADDR_W-1:0] cpu_addr;
    word_t             cpu_wdata;
    logic              flush;
    logic              cpu_ack;
    word_t             cpu_rdata;
    logic              l2_req;
    logic              l2_we;
    logic [ADDR_W-1:0] l2_addr;
    logic [LINE_W-1:0] l2_wline;
    logic              l2_ack;
    logic [LINE_W-1:0] l2_rline;

    // reference model with a memory image and a shadow cache
    word_t            ref_mem [MEM_WORDS];
    word_t            shadow [SETS][WORDS_PER_LINE];
    logic [TAG_W-1:0] shadow_tag [SETS];
    logic             shadow_valid [SETS];
    logic             shadow_dirty [SETS];

    logic [31:0]       lfsr;
    int                checks;
    int                errors;
    int                mark_checks;
    int                mark_errors;
    int                cycles;
    int                cpu_reqs;
    int                cpu_acks;
    int                l2_reqs;
    int                l2_acks;
    logic              cpu_req_q;
    logic              cpu_ack_q;
    logic              l2_req_q;
    logic              l2_ack_q;
    logic              log_we [$];
    logic [ADDR_W-1:0] log_addr [$];

    l1d_cache_top #(
        .INDEX_W        (INDEX_W),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) dut_i (
        .clk       (clk),
        .nrst      (nrst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush     (flush),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wline  (l2_wline),
        .l2_ack    (l2_ack),
        .l2_rline  (l2_rline)
    );

    l2_mem_model #(
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .MEM_WORDS      (MEM_WORDS),
        .FILL_KEY       (FILL_KEY),
        .SEED           (SEED)
    ) mem_i (
        .clk      (clk),
        .nrst     (nrst),
        .l2_req   (l2_req),
        .l2_we    (l2_we),
        .l2_addr  (l2_addr),
        .l2_wline (l2_wline),
        .l2_ack   (l2_ack),
        .l2_rline (l2_rline)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // small window of four sets and four tags
    function automatic logic [ADDR_W-1:0] window_addr();
        logic [TAG_W-1:0]   t;
        logic [INDEX_W-1:0] idx;
        logic [SEL_W-1:0]   w;
        t   = take_bits(2);
        idx = take_bits(2);
        w   = take_bits(SEL_W);
        return {t, idx, w, 2'b00};
    endfunction

    function automatic int line_base(input logic [TAG_W-1:0] t, input logic [INDEX_W-1:0] idx);
        logic [ADDR_W-1:0] a;
        a = {t, idx, {OFFSET_W{1'b0}}};
        return (a >> 2) % MEM_WORDS;
    endfunction

    function automatic word_t model_access(input logic [ADDR_W-1:0] addr, input logic we,
                                           input word_t wdata);
        logic [TAG_W-1:0]   t;
        logic [INDEX_W-1:0] idx;
        logic [SEL_W-1:0]   w;
        int                 base;
        t   = addr[ADDR_W-1 -: TAG_W];
        idx = addr[OFFSET_W +: INDEX_W];
        w   = addr[2 +: SEL_W];
        if (!shadow_valid[idx] || (shadow_tag[idx] != t))
        begin
            // dirty victim goes back before the refill
            if (shadow_valid[idx] && shadow_dirty[idx])
            begin
                base = line_base(shadow_tag[idx], idx);
                for (int k = 0; k < WORDS_PER_LINE; k++)
                    ref_mem[base + k] = shadow[idx][k];
            end
            base = line_base(t, idx);
            for (int k = 0; k < WORDS_PER_LINE; k++)
                shadow[idx][k] = ref_mem[base + k];
            shadow_tag[idx]   = t;
            shadow_valid[idx] = 1'b1;
            shadow_dirty[idx] = 1'b0;
        end
        if (we)
        begin
            shadow[idx][w]    = wdata;
            shadow_dirty[idx] = 1'b1;
        end
        return shadow[idx][w];
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // one four-phase cpu access with hold extra cycles before req drops
    task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic we, input word_t wdata,
                              input int hold, output word_t rdata);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        @(negedge clk);
        while (!cpu_ack)
            @(negedge clk);
        rdata = cpu_rdata;
        repeat (hold)
            @(posedge clk);
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        while (cpu_ack)
            @(negedge clk);
    endtask

    task automatic checked_access(input logic [ADDR_W-1:0] addr, input logic we,
                                  input word_t wdata, input int hold);
        word_t exp;
        word_t got;
        exp = model_access(addr, we, wdata);
        cpu_access(addr, we, wdata, hold, got);
        if (!we)
            check_word(got, exp, $sformatf("read of %h", addr));
    endtask

    // handshake rules on both sides sampled mid-cycle
    always @(negedge clk)
    begin
        if (nrst)
        begin
            if (cpu_ack && !cpu_ack_q && !cpu_req)
            begin
                errors++;
                $display("cpu_ack rose at %0t ns while cpu_req was low", $time);
            end
            if (cpu_req && !cpu_req_q)
            begin
                cpu_reqs++;
                if (cpu_ack)
                begin
                    errors++;
                    $display("new cpu request at %0t ns before cpu_ack went low", $time);
                end
            end
            if (!cpu_ack && cpu_ack_q)
                cpu_acks++;
            if (l2_req && !l2_req_q)
            begin
                l2_reqs++;
                log_we.push_back(l2_we);
                log_addr.push_back(l2_addr);
                if (l2_ack)
                begin
                    errors++;
                    $display("l2_req rose at %0t ns before l2_ack went low", $time);
                end
            end
            if (l2_ack && !l2_ack_q && !l2_req)
            begin
                errors++;
                $display("l2_ack rose at %0t ns while l2_req was low", $time);
            end
            if (!l2_ack && l2_ack_q)
                l2_acks++;
        end
        cpu_req_q = cpu_req;
        cpu_ack_q = cpu_ack;
        l2_req_q  = l2_req;
        l2_ack_q  = l2_ack;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        logic [ADDR_W-1:0] a_addr;
        logic [ADDR_W-1:0] b_addr;
        word_t             wd;
        word_t             rd;
        word_t             old_a;
        word_t             old_b;
        lfsr = SEED;
        checks = 0;
        errors = 0;
        mark_checks = 0;
        mark_errors = 0;
        cycles = 0;
        cpu_reqs = 0;
        cpu_acks = 0;
        l2_reqs = 0;
        l2_acks = 0;
        cpu_req_q = 1'b0;
        cpu_ack_q = 1'b0;
        l2_req_q = 1'b0;
        l2_ack_q = 1'b0;
        nrst = 1'b0;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        flush = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = i ^ FILL_KEY;
        for (int s = 0; s < SETS; s++)
        begin
            shadow_valid[s] = 1'b0;
            shadow_dirty[s] = 1'b0;
            shadow_tag[s]   = '0;
        end
        repeat (5)
            @(posedge clk);
        nrst <= 1'b1;

        @(negedge clk);
        check_word({31'b0, cpu_ack}, 32'd0, "cpu_ack after reset");
        check_word({31'b0, l2_req}, 32'd0, "l2_req after reset");
        end_test("reset");

        for (int n = 0; n < RAND_ACCESSES; n++)
            checked_access(window_addr(), take_bits(1), take_bits(32), 0);
        end_test("random access");

        // set 40 with tags 1 and 2
        a_addr = {20'd1, 6'd40, 4'd5, 2'b00};
        b_addr = {20'd2, 6'd40, 4'd5, 2'b00};
        wd = take_bits(32);
        checked_access(a_addr, 1'b1, wd, 0);
        log_we.delete();
        log_addr.delete();
        checked_access(b_addr, 1'b0, '0, 0);
        checks++;
        if ((log_we.size() != 2) || (log_we[0] !== 1'b1) || (log_we[1] !== 1'b0) ||
            (log_addr[0] !== {a_addr[31:6], 6'd0}) || (log_addr[1] !== {b_addr[31:6], 6'd0}))
        begin
            errors++;
            $display("Fail at %0t ns: no write-back of line %h before refill of line %h",
                     $time, {a_addr[31:6], 6'd0}, {b_addr[31:6], 6'd0});
        end
        check_word(mem_i.mem[a_addr >> 2], wd, "L2 word after write-back");
        end_test("conflict write-back");

        a_addr = {20'd3, 6'd41, 4'd7, 2'b00};
        checked_access(a_addr, 1'b1, take_bits(32), 0);
        for (int w = 0; w < WORDS_PER_LINE; w++)
            checked_access({a_addr[31:6], w[3:0], 2'b00}, 1'b0, '0, 0);
        end_test("write miss merge");

        // writes to fresh sets with the old memory words kept aside
        a_addr = {20'd1, 6'd42, 4'd3, 2'b00};
        b_addr = {20'd2, 6'd43, 4'd9, 2'b00};
        old_a = ref_mem[a_addr >> 2];
        old_b = ref_mem[b_addr >> 2];
        checked_access(a_addr, 1'b1, take_bits(32), 0);
        checked_access(b_addr, 1'b1, take_bits(32), 0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int s = 0; s < SETS; s++)
        begin
            shadow_valid[s] = 1'b0;
            shadow_dirty[s] = 1'b0;
        end
        void'(model_access(a_addr, 1'b0, '0));
        cpu_access(a_addr, 1'b0, '0, 0, rd);
        check_word(rd, old_a, "read after flush");
        void'(model_access(b_addr, 1'b0, '0));
        cpu_access(b_addr, 1'b0, '0, 0, rd);
        check_word(rd, old_b, "read after flush");
        end_test("flush drops dirty data");

        for (int n = 0; n < DELAY_ACCESSES; n++)
        begin
            repeat (take_bits(2))
                @(posedge clk);
            checked_access(window_addr(), take_bits(1), take_bits(32), take_bits(2));
        end
        @(posedge clk);
        check_word(cpu_acks, cpu_reqs, "completed cpu handshakes");
        check_word(l2_acks, l2_reqs, "completed L2 handshakes");
        end_test("random delays");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/l1d_pkg.sv
hdl/l1d_controller.sv
hdl/l1d_data_array.sv
hdl/l2_handshake.sv
hdl/l1d_cache_top.sv
sim/l2_mem_model.sv
sim/l1d_cache_tb.sv
